//--- include/vint_macros.svh
// --------------------------------------------------
// Integer ALU execute unit, shared widths
// Word size, lane count and bookkeeping field widths
// --------------------------------------------------

`ifndef VINT_MACROS_SVH
`define VINT_MACROS_SVH

// Datapath word width
`define VINT_XLEN 64

// Default number of SIMT lanes per request
`define VINT_NUM_LANES 4

// Warp id width
`define VINT_NW_BITS 3

// Destination register index width
`define VINT_NR_BITS 5

// ALU opcode word, is_w + op_class + func
`define VINT_OP_BITS 5

`endif

//--- hdl/vint_pkg.sv
// --------------------------------------------------
// Integer ALU execute unit, shared types
// Opcode union and the op_class encodings
// --------------------------------------------------

`include "vint_macros.svh"

package vint_pkg;

    // Decoded view of the opcode word, MSB first
    typedef struct packed {
        logic       is_w;     // 32-bit form, sign-extended result
        logic [1:0] op_class;
        logic [1:0] func;     // Meaning depends on op_class
    } alu_fields_t;

    // Same word seen raw by dispatch and decoded by the lanes
    typedef union packed {
        logic [`VINT_OP_BITS-1:0] raw;
        alu_fields_t              fields;
    } alu_op_t;

    // op_class values
    localparam logic [1:0] CLASS_ADD = 2'd0; // func ignored
    localparam logic [1:0] CLASS_SUB = 2'd1; // SUB, SLT, SLTU
    localparam logic [1:0] CLASS_SHR = 2'd2; // SRL, SRA
    localparam logic [1:0] CLASS_MSC = 2'd3; // AND, OR, XOR, SLL

    // func values inside CLASS_SUB
    localparam logic [1:0] FUNC_SUB  = 2'd0;
    localparam logic [1:0] FUNC_SLT  = 2'd1;
    localparam logic [1:0] FUNC_SLTU = 2'd2;

    // func values inside CLASS_MSC
    localparam logic [1:0] FUNC_AND  = 2'd0;
    localparam logic [1:0] FUNC_OR   = 2'd1;
    localparam logic [1:0] FUNC_XOR  = 2'd2;
    localparam logic [1:0] FUNC_SLL  = 2'd3;

    // Inside CLASS_SHR only func[0] counts, set for SRA

endpackage

//--- hdl/vint_dispatch.sv
// --------------------------------------------------
// Dispatch register of the integer ALU unit
// Takes one execute request and picks operand B
// --------------------------------------------------

`timescale 1ns/1ps

`include "vint_macros.svh"

module vint_dispatch #(
    parameter int NUM_LANES = `VINT_NUM_LANES
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Execute request
    input  logic                                 exec_valid,
    output logic                                 exec_ready,
    input  vint_pkg::alu_op_t                    exec_op,
    input  logic                                 exec_use_imm,
    input  logic [`VINT_XLEN-1:0]                exec_imm,
    input  logic [NUM_LANES-1:0][`VINT_XLEN-1:0] exec_rs1_data,
    input  logic [NUM_LANES-1:0][`VINT_XLEN-1:0] exec_rs2_data,
    input  logic [NUM_LANES-1:0]                 exec_tmask,
    input  logic [`VINT_NW_BITS-1:0]             exec_wid,
    input  logic [`VINT_NR_BITS-1:0]             exec_rd,
    input  logic [`VINT_XLEN-1:0]                exec_pc,

    // Registered request towards the lane ALUs
    output logic                                 disp_valid,
    input  logic                                 disp_ready,
    output vint_pkg::alu_op_t                    disp_op,
    output logic [NUM_LANES-1:0][`VINT_XLEN-1:0] disp_a,
    output logic [NUM_LANES-1:0][`VINT_XLEN-1:0] disp_b,
    output logic [NUM_LANES-1:0]                 disp_tmask,
    output logic [`VINT_NW_BITS-1:0]             disp_wid,
    output logic [`VINT_NR_BITS-1:0]             disp_rd,
    output logic [`VINT_XLEN-1:0]                disp_pc
);

    logic                                 accept;
    logic [NUM_LANES-1:0][`VINT_XLEN-1:0] imm_bcast;
    logic [NUM_LANES-1:0][`VINT_XLEN-1:0] b_sel;

    // One-entry stage, free when empty or draining this cycle
    assign exec_ready = !disp_valid || disp_ready;
    assign accept     = exec_valid && exec_ready;

    // Immediate goes to every lane
    assign imm_bcast = {NUM_LANES{exec_imm}};
    assign b_sel     = exec_use_imm ? imm_bcast : exec_rs2_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp_valid <= 1'b0;
        end else if (exec_ready) begin
            disp_valid <= exec_valid; // Refill or go empty
        end
    end

    // Payload only moves on an accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            disp_op.raw <= exec_op.raw;
            disp_a      <= exec_rs1_data;
            disp_b      <= b_sel;
            disp_tmask  <= exec_tmask;
            disp_wid    <= exec_wid;
            disp_rd     <= exec_rd;
            disp_pc     <= exec_pc;
        end
    end

endmodule

//--- hdl/vint_lane_alu.sv
// --------------------------------------------------
// Single-lane integer ALU, purely combinational
// Add, sub/compare, shifts and logic, 64 and W forms
// --------------------------------------------------

`timescale 1ns/1ps

`include "vint_macros.svh"

module vint_lane_alu (
    input  vint_pkg::alu_op_t      op,
    input  logic [`VINT_XLEN-1:0]  a,
    input  logic [`VINT_XLEN-1:0]  b,
    output logic [`VINT_XLEN-1:0]  result
);

    import vint_pkg::*;

    localparam int XLEN = `VINT_XLEN;

    logic            cmp_signed;
    logic            shr_arith;
    logic [5:0]      shamt;
    logic [XLEN-1:0] add_res;
    logic [XLEN:0]   sub_diff;   // Extended by one bit for compares
    logic [32:0]     sub_diff_w;
    logic [XLEN-1:0] sub_res;
    logic [31:0]     sub_res_w;
    logic [XLEN-1:0] shr_res;
    logic [31:0]     shr_res_w;
    logic [XLEN-1:0] msc_res;
    logic [31:0]     msc_res_w;
    logic [31:0]     add_res_w;

    assign cmp_signed = (op.fields.func == FUNC_SLT);
    assign shr_arith  = op.fields.func[0];
    assign shamt      = op.fields.is_w ? {1'b0, b[4:0]} : b[5:0];

    assign add_res   = a + b;
    assign add_res_w = a[31:0] + b[31:0];

    // Sign or zero extension decides SLT against SLTU
    assign sub_diff   = {cmp_signed & a[XLEN-1], a} - {cmp_signed & b[XLEN-1], b};
    assign sub_diff_w = {cmp_signed & a[31], a[31:0]} - {cmp_signed & b[31], b[31:0]};

    always_comb begin
        case (op.fields.func)
            FUNC_SLT, FUNC_SLTU: begin
                sub_res   = {{(XLEN-1){1'b0}}, sub_diff[XLEN]};
                sub_res_w = {31'b0, sub_diff_w[32]};
            end
            default: begin
                sub_res   = sub_diff[XLEN-1:0];
                sub_res_w = sub_diff_w[31:0];
            end
        endcase
    end

    assign shr_res   = XLEN'($signed({shr_arith & a[XLEN-1], a}) >>> shamt);
    assign shr_res_w = 32'($signed({shr_arith & a[31], a[31:0]}) >>> shamt[4:0]);

    always_comb begin
        case (op.fields.func)
            FUNC_AND: msc_res = a & b;
            FUNC_OR:  msc_res = a | b;
            FUNC_XOR: msc_res = a ^ b;
            default:  msc_res = a << shamt; // SLL
        endcase
        msc_res_w = msc_res[31:0]; // Low half fits the W form, shamt already 5 bits
    end

    // W results take the low word and sign-extend it
    always_comb begin
        case ({op.fields.is_w, op.fields.op_class})
            {1'b0, CLASS_ADD}: result = add_res;
            {1'b0, CLASS_SUB}: result = sub_res;
            {1'b0, CLASS_SHR}: result = shr_res;
            {1'b0, CLASS_MSC}: result = msc_res;
            {1'b1, CLASS_ADD}: result = {{32{add_res_w[31]}}, add_res_w};
            {1'b1, CLASS_SUB}: result = {{32{sub_res_w[31]}}, sub_res_w};
            {1'b1, CLASS_SHR}: result = {{32{shr_res_w[31]}}, shr_res_w};
            default:           result = {{32{msc_res_w[31]}}, msc_res_w};
        endcase
    end

endmodule

//--- hdl/vint_commit_buffer.sv
// --------------------------------------------------
// Two-slot elastic buffer in front of the commit port
// Registered ready, no path from out_ready to in_ready
// --------------------------------------------------

`timescale 1ns/1ps

module vint_commit_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [DATAW-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [DATAW-1:0] out_data
);

    logic [DATAW-1:0] slot_data [2];
    logic [1:0]       slot_full;
    logic             rd_ptr;
    logic             wr_sel;
    logic             push;
    logic             pop;

    // Only back-pressure when both slots hold data
    assign in_ready  = !(slot_full[0] && slot_full[1]);
    assign out_valid = slot_full[rd_ptr];
    assign out_data  = slot_data[rd_ptr];

    // Oldest entry sits at rd_ptr, the next free slot follows it
    assign wr_sel = slot_full[rd_ptr] ? !rd_ptr : rd_ptr;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_full <= 2'b00;
            rd_ptr    <= 1'b0;
        end else begin
            // Push and pop never hit the same slot
            if (push) begin
                slot_full[wr_sel] <= 1'b1;
            end
            if (pop) begin
                slot_full[rd_ptr] <= 1'b0;
                rd_ptr            <= !rd_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slot_data[wr_sel] <= in_data;
        end
    end

endmodule

//--- hdl/vint_unit.sv
// --------------------------------------------------
// Integer ALU execute unit for a SIMT core
// Dispatch register, per-lane ALUs, commit buffer
// --------------------------------------------------

`timescale 1ns/1ps

`include "vint_macros.svh"

module vint_unit #(
    parameter int NUM_LANES = `VINT_NUM_LANES
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Execute port
    input  logic                                 exec_valid,
    output logic                                 exec_ready,
    input  vint_pkg::alu_op_t                    exec_op,
    input  logic                                 exec_use_imm,
    input  logic [`VINT_XLEN-1:0]                exec_imm,
    input  logic [NUM_LANES-1:0][`VINT_XLEN-1:0] exec_rs1_data,
    input  logic [NUM_LANES-1:0][`VINT_XLEN-1:0] exec_rs2_data,
    input  logic [NUM_LANES-1:0]                 exec_tmask,
    input  logic [`VINT_NW_BITS-1:0]             exec_wid,
    input  logic [`VINT_NR_BITS-1:0]             exec_rd,
    input  logic [`VINT_XLEN-1:0]                exec_pc,

    // Commit port
    output logic                                 commit_valid,
    input  logic                                 commit_ready,
    output logic [NUM_LANES-1:0][`VINT_XLEN-1:0] commit_data,
    output logic [NUM_LANES-1:0]                 commit_tmask,
    output logic [`VINT_NW_BITS-1:0]             commit_wid,
    output logic [`VINT_NR_BITS-1:0]             commit_rd,
    output logic [`VINT_XLEN-1:0]                commit_pc
);

    import vint_pkg::*;

    // Lane results plus warp bookkeeping
    localparam int DATAW = NUM_LANES * `VINT_XLEN + NUM_LANES
                         + `VINT_NW_BITS + `VINT_NR_BITS + `VINT_XLEN;

    logic                                 disp_valid;
    logic                                 buf_in_ready;
    alu_op_t                              disp_op;
    logic [NUM_LANES-1:0][`VINT_XLEN-1:0] disp_a;
    logic [NUM_LANES-1:0][`VINT_XLEN-1:0] disp_b;
    logic [NUM_LANES-1:0]                 disp_tmask;
    logic [`VINT_NW_BITS-1:0]             disp_wid;
    logic [`VINT_NR_BITS-1:0]             disp_rd;
    logic [`VINT_XLEN-1:0]                disp_pc;
    logic [NUM_LANES-1:0][`VINT_XLEN-1:0] buf_in_data;

    vint_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .exec_valid    (exec_valid),
        .exec_ready    (exec_ready),
        .exec_op       (exec_op),
        .exec_use_imm  (exec_use_imm),
        .exec_imm      (exec_imm),
        .exec_rs1_data (exec_rs1_data),
        .exec_rs2_data (exec_rs2_data),
        .exec_tmask    (exec_tmask),
        .exec_wid      (exec_wid),
        .exec_rd       (exec_rd),
        .exec_pc       (exec_pc),
        .disp_valid    (disp_valid),
        .disp_ready    (buf_in_ready),
        .disp_op       (disp_op),
        .disp_a        (disp_a),
        .disp_b        (disp_b),
        .disp_tmask    (disp_tmask),
        .disp_wid      (disp_wid),
        .disp_rd       (disp_rd),
        .disp_pc       (disp_pc)
    );

    // Every lane computes, tmask only travels along
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        vint_lane_alu u_alu (
            .op     (disp_op),
            .a      (disp_a[i]),
            .b      (disp_b[i]),
            .result (buf_in_data[i])
        );
    end

    vint_commit_buffer #(
        .DATAW (DATAW)
    ) u_commit_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (disp_valid),
        .in_ready  (buf_in_ready),
        .in_data   ({buf_in_data, disp_tmask, disp_wid, disp_rd, disp_pc}),
        .out_valid (commit_valid),
        .out_ready (commit_ready),
        .out_data  ({commit_data, commit_tmask, commit_wid, commit_rd, commit_pc})
    );

endmodule

//--- verif/vint_props.sv
// --------------------------------------------------
// Handshake and latency properties of the ALU unit
// Attached to vint_unit by bind
// --------------------------------------------------

`timescale 1ns/1ps

`include "vint_macros.svh"

module vint_props #(
    parameter int NUM_LANES = `VINT_NUM_LANES
) (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 exec_valid,
    input logic                                 exec_ready,
    input vint_pkg::alu_op_t                    exec_op,
    input logic                                 exec_use_imm,
    input logic [`VINT_XLEN-1:0]                exec_imm,
    input logic [NUM_LANES-1:0][`VINT_XLEN-1:0] exec_rs1_data,
    input logic [NUM_LANES-1:0][`VINT_XLEN-1:0] exec_rs2_data,
    input logic [NUM_LANES-1:0]                 exec_tmask,
    input logic [`VINT_NW_BITS-1:0]             exec_wid,
    input logic [`VINT_NR_BITS-1:0]             exec_rd,
    input logic [`VINT_XLEN-1:0]                exec_pc,
    input logic                                 commit_valid,
    input logic                                 commit_ready,
    input logic [NUM_LANES-1:0][`VINT_XLEN-1:0] commit_data,
    input logic [NUM_LANES-1:0]                 commit_tmask,
    input logic [`VINT_NW_BITS-1:0]             commit_wid,
    input logic [`VINT_NR_BITS-1:0]             commit_rd,
    input logic [`VINT_XLEN-1:0]                commit_pc
);

    int violations = 0; // Read by the testbench

    // Source keeps its request steady until accepted
    a_exec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        exec_valid && !exec_ready |=> exec_valid && $stable({exec_op.raw, exec_use_imm,
            exec_imm, exec_rs1_data, exec_rs2_data, exec_tmask, exec_wid, exec_rd, exec_pc}))
    else begin
        $error("execute request changed while stalled");
        violations++;
    end

    a_commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable({commit_data,
            commit_tmask, commit_wid, commit_rd, commit_pc}))
    else begin
        $error("commit output changed while stalled");
        violations++;
    end

    // Idle during reset and on the first edge after it
    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !commit_valid && exec_ready)
    else begin
        $error("unit not idle during or after reset");
        violations++;
    end

    // Empty output plus ready commit port gives two-cycle latency
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        exec_valid && exec_ready && !commit_valid ##1 commit_ready
        |=> commit_valid && commit_pc == $past(exec_pc, 2) && commit_rd == $past(exec_rd, 2))
    else begin
        $error("request did not commit two cycles after acceptance");
        violations++;
    end

endmodule

bind vint_unit vint_props #(
    .NUM_LANES (NUM_LANES)
) u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .exec_valid    (exec_valid),
    .exec_ready    (exec_ready),
    .exec_op       (exec_op),
    .exec_use_imm  (exec_use_imm),
    .exec_imm      (exec_imm),
    .exec_rs1_data (exec_rs1_data),
    .exec_rs2_data (exec_rs2_data),
    .exec_tmask    (exec_tmask),
    .exec_wid      (exec_wid),
    .exec_rd       (exec_rd),
    .exec_pc       (exec_pc),
    .commit_valid  (commit_valid),
    .commit_ready  (commit_ready),
    .commit_data   (commit_data),
    .commit_tmask  (commit_tmask),
    .commit_wid    (commit_wid),
    .commit_rd     (commit_rd),
    .commit_pc     (commit_pc)
);

//--- verif/vint_tb.sv
// --------------------------------------------------
// Testbench for the integer ALU execute unit
// Random and corner operands, reference model,
// result queue checked on every commit transfer
// --------------------------------------------------

`timescale 1ns/1ps

`include "vint_macros.svh"

module vint_tb;

    import vint_pkg::*;

    localparam int NL         = `VINT_NUM_LANES;
    localparam int XLEN       = `VINT_XLEN;
    localparam int NW         = `VINT_NW_BITS;
    localparam int NR         = `VINT_NR_BITS;
    localparam int WAIT_LIMIT = 200; // Cycles per handshake wait

    typedef logic [NL-1:0][XLEN-1:0] lanes_t;

    typedef struct packed {
        lanes_t          data;
        logic [NL-1:0]   tmask;
        logic [NW-1:0]   wid;
        logic [NR-1:0]   rd;
        logic [XLEN-1:0] pc;
    } commit_t;

    logic            clk;
    logic            rst_n;
    logic            exec_valid;
    logic            exec_ready;
    alu_op_t         exec_op;
    logic            exec_use_imm;
    logic [XLEN-1:0] exec_imm;
    lanes_t          exec_rs1_data;
    lanes_t          exec_rs2_data;
    logic [NL-1:0]   exec_tmask;
    logic [NW-1:0]   exec_wid;
    logic [NR-1:0]   exec_rd;
    logic [XLEN-1:0] exec_pc;
    logic            commit_valid;
    logic            commit_ready;
    lanes_t          commit_data;
    logic [NL-1:0]   commit_tmask;
    logic [NW-1:0]   commit_wid;
    logic [NR-1:0]   commit_rd;
    logic [XLEN-1:0] commit_pc;

    integer     seed       = 52;
    integer     ready_seed = 52; // Own stream for commit_ready
    bit         random_ready = 1'b0;
    bit         ready_level  = 1'b1;
    bit         saw_stall    = 1'b0;
    int         sent         = 0;
    int         committed    = 0;
    commit_t    expected_q[$];
    logic [4:0] ops[$];

    vint_unit dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // Reference model straight from the opcode encoding
    function automatic logic [XLEN-1:0] alu_model(logic [4:0] op, logic [63:0] a,
                                                  logic [63:0] b);
        logic [31:0] aw;
        logic [31:0] bw;
        logic [31:0] rw;
        logic [63:0] r;
        aw = a[31:0];
        bw = b[31:0];
        case (op[3:2])
            CLASS_ADD: begin
                r  = a + b;
                rw = aw + bw;
            end
            CLASS_SUB: begin
                if (op[1:0] == FUNC_SLT) begin
                    r  = 64'($signed(a) < $signed(b));
                    rw = 32'($signed(aw) < $signed(bw));
                end else if (op[1:0] == FUNC_SLTU) begin
                    r  = 64'(a < b);
                    rw = 32'(aw < bw);
                end else begin
                    r  = a - b;
                    rw = aw - bw;
                end
            end
            CLASS_SHR: begin
                if (op[0]) begin
                    r  = $signed(a) >>> b[5:0];
                    rw = $signed(aw) >>> bw[4:0];
                end else begin
                    r  = a >> b[5:0];
                    rw = aw >> bw[4:0];
                end
            end
            default: begin
                case (op[1:0])
                    FUNC_AND: r = a & b;
                    FUNC_OR:  r = a | b;
                    FUNC_XOR: r = a ^ b;
                    default:  r = a << b[5:0];
                endcase
                rw = (op[1:0] == FUNC_SLL) ? aw << bw[4:0] : r[31:0];
            end
        endcase
        return op[4] ? {{32{rw[31]}}, rw} : r;
    endfunction

    function automatic bit is_shift(logic [4:0] op);
        return op[3:2] == CLASS_SHR || op[3:0] == {CLASS_MSC, FUNC_SLL};
    endfunction

    // Random word with an occasional sign or width corner
    function automatic logic [XLEN-1:0] pick_operand();
        logic [XLEN-1:0] r;
        r = {$random(seed), $random(seed)};
        case ($unsigned($random(seed)) % 8)
            0: r = 64'h8000_0000_0000_0000;
            1: r = 64'hffff_ffff_ffff_ffff;
            2: r = 64'h7fff_ffff_ffff_ffff;
            3: r = 64'h0000_0000_8000_0000;
            default: ;
        endcase
        return r;
    endfunction

    // Negative shamt_base leaves operand B fully random and the mask random
    task automatic send(input logic [4:0] op, input logic use_imm, input int shamt_base);
        int waited;
        for (int i = 0; i < NL; i++) begin
            exec_rs1_data[i] = pick_operand();
            exec_rs2_data[i] = pick_operand();
            if (shamt_base >= 0) begin
                exec_rs2_data[i][5:0] = 6'(shamt_base + i); // W forms must ignore bit 5
            end
        end
        exec_imm = pick_operand();
        if (shamt_base >= 0) begin
            exec_imm[5:0] = 6'(shamt_base);
        end
        exec_op.raw  = op;
        exec_use_imm = use_imm;
        exec_tmask   = (shamt_base < 0 && $unsigned($random(seed)) % 4 == 0) ?
                       NL'($random(seed)) : '1;
        exec_wid     = NW'($random(seed));
        exec_rd      = NR'($random(seed));
        exec_pc      = {$random(seed), $random(seed)};
        exec_valid   = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!exec_ready && waited < WAIT_LIMIT);
        if (!exec_ready) begin
            $display("Timeout: execute request was not accepted within %0d cycles", waited);
            abort_run();
        end
        @(negedge clk);
        exec_valid = 1'b0;
    endtask

    // Switch mode on the rising edge away from the ready driver
    task automatic set_ready_mode(input bit rnd, input bit level);
        @(posedge clk);
        random_ready = rnd;
        ready_level  = level;
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (random_ready) begin
            commit_ready = ($unsigned($random(ready_seed)) % 4) == 0; // Mostly stalled
        end else begin
            commit_ready = ready_level;
        end
    end

    always @(negedge clk) begin
        if (dut.u_props.violations != 0) begin
            $display("A handshake or latency property of the unit was violated");
            abort_run();
        end
    end

    // Check the commit before recording this edge's accepted request
    always @(posedge clk) begin
        commit_t exp;
        if (rst_n && commit_valid && commit_ready) begin
            if (expected_q.size() == 0) begin
                $display("A commit transfer arrived with no request outstanding");
                abort_run();
            end else begin
                exp = expected_q.pop_front();
                for (int i = 0; i < NL; i++) begin
                    if (exp.tmask[i]) begin
                        assert (commit_data[i] == exp.data[i])
                        else report_mismatch($sformatf("lane %0d result %h, expected %h",
                                             i, commit_data[i], exp.data[i]));
                    end
                end
                assert (commit_tmask == exp.tmask && commit_wid == exp.wid
                        && commit_rd == exp.rd && commit_pc == exp.pc)
                else report_mismatch($sformatf("bookkeeping pc %h rd %0d, expected pc %h rd %0d",
                                     commit_pc, commit_rd, exp.pc, exp.rd));
                committed++;
            end
        end
        if (rst_n && exec_valid && exec_ready) begin
            for (int i = 0; i < NL; i++) begin
                exp.data[i] = alu_model(exec_op.raw, exec_rs1_data[i],
                                        exec_use_imm ? exec_imm : exec_rs2_data[i]);
            end
            exp.tmask = exec_tmask;
            exp.wid   = exec_wid;
            exp.rd    = exec_rd;
            exp.pc    = exec_pc;
            expected_q.push_back(exp);
            sent++;
        end
        if (rst_n && exec_valid && !exec_ready) begin
            saw_stall = 1'b1;
        end
    end

    initial begin
        int waited;
        rst_n         = 1'b0;
        exec_valid    = 1'b0;
        exec_op       = '0;
        exec_use_imm  = 1'b0;
        exec_imm      = '0;
        exec_rs1_data = '0;
        exec_rs2_data = '0;
        exec_tmask    = '0;
        exec_wid      = '0;
        exec_rd       = '0;
        exec_pc       = '0;
        commit_ready  = 1'b1;
        // Every defined opcode except SUB class func 3
        for (int w = 0; w < 2; w++) begin
            for (int c = 0; c < 4; c++) begin
                for (int f = 0; f < 4; f++) begin
                    if (!(c == CLASS_SUB && f == 3)) begin
                        ops.push_back({w[0], c[1:0], f[1:0]});
                    end
                end
            end
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (exec_ready && !commit_valid)
        else begin
            $display("Unit not idle after reset, exec_ready low or commit_valid high");
            abort_run();
        end

        // Isolated requests with register then immediate operand
        foreach (ops[k]) begin
            send(ops[k], 1'b0, -1);
            repeat (3) @(negedge clk);
            send(ops[k], 1'b1, -1);
            repeat (3) @(negedge clk);
        end

        // Shift sweep 0..63 under random back-pressure
        set_ready_mode(1'b1, 1'b1);
        foreach (ops[k]) begin
            for (int s = 0; s < 64; s += NL) begin
                if (is_shift(ops[k])) begin
                    send(ops[k], 1'b0, s);
                    send(ops[k], 1'b1, s);
                end else begin
                    send(ops[k], 1'($random(seed)), -1);
                end
            end
        end

        // Back-to-back stream with the commit port always ready
        set_ready_mode(1'b0, 1'b1);
        for (int n = 0; n < 40; n++) begin
            send(ops[$unsigned($random(seed)) % ops.size()], 1'($random(seed)), -1);
        end

        waited = 0;
        while (expected_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("Timeout: %0d results never reached the commit port", expected_q.size());
            abort_run();
        end
        if (!saw_stall) begin
            $display("exec_ready never dropped while the commit port was stalled");
            abort_run();
        end
        if (dut.u_props.violations == 0 && committed == sent) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d requests sent, %0d committed, %0d property violations",
                     sent, committed, dut.u_props.violations);
            abort_run();
        end
    end

endmodule

//--- project.f
+incdir+include
hdl/vint_pkg.sv
hdl/vint_dispatch.sv
hdl/vint_lane_alu.sv
hdl/vint_commit_buffer.sv
hdl/vint_unit.sv
verif/vint_props.sv
verif/vint_tb.sv
